// ==== hdl/spixpress_cfg.svh ====
// SPI flash read controller build constants: flash size, read command, timer loads, control bits
`ifndef SPIXPRESS_CFG_SVH
`define SPIXPRESS_CFG_SVH

// Log2 of the flash size in bytes
`define SPIX_LGSZ 19

// Word address width, bus addresses are 32-bit words
`define SPIX_AW (`SPIX_LGSZ - 2)

// Slow read command, good up to about 50 MHz SCK
`define SPIX_READ_CMD 8'h03

// Bit timer loads
// Command, address and data for a fresh read
`define SPIX_LOAD_FIRST 7'd65
// Data only, when the next sequential word is streamed
`define SPIX_LOAD_NEXT 7'd32
// One user byte plus the load cycle
`define SPIX_LOAD_USER 7'd9

// Chip select bit of the control port word
`define SPIX_CSN_BIT 8

`endif

// ==== hdl/spixpress_pkg.sv ====
// Shared types of the SPI flash read controller: control word, address and timer load kind
`include "spixpress_cfg.svh"

package spixpress_pkg;

	// Word address on the bus side
	typedef logic [`SPIX_AW-1:0] spix_addr_t;

	// Bits left in the current SPI transfer
	typedef logic [6:0] spix_count_t;

	// What the bit timer should load on the next edge
	typedef enum logic [1:0] {
		LOAD_NONE  = 2'd0,
		LOAD_FIRST = 2'd1,
		LOAD_NEXT  = 2'd2,
		LOAD_USER  = 2'd3
	} spix_load_e;

	// Bus data word
	// Memory reads use the raw view, the control port uses the fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [22:0] unused;
			logic        cs_n;
			logic [7:0]  spi_byte;
		} fields;
	} spix_cfg_u;

endpackage

// ==== hdl/spixpress_bit_timer.sv ====
// SPI bit timer that counts the clock cycles left in the current flash transfer
`timescale 1ns/1ps
`include "spixpress_cfg.svh"

module spixpress_bit_timer (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_wb_cyc,
	input  spixpress_pkg::spix_load_e  i_load,
	output spixpress_pkg::spix_count_t o_count
);
	import spixpress_pkg::*;

	// Load on request, else run down to zero and hold
	// Bus abort clears the count along with the transfer
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_count <= '0;
		else
		begin
			case (i_load)
				LOAD_FIRST:
					o_count <= `SPIX_LOAD_FIRST;
				LOAD_NEXT:
					o_count <= `SPIX_LOAD_NEXT;
				LOAD_USER:
					o_count <= `SPIX_LOAD_USER;
				default:
				begin
					if (o_count != '0)
						o_count <= o_count - 1'b1;
				end
			endcase
		end
	end

	// A new count starts only as the previous transfer ends
	assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wb_cyc && (i_load != LOAD_NONE)) |-> (o_count <= 7'd1));

endmodule

// ==== hdl/spixpress_mosi_shift.sv ====
// SPI MOSI shifter: loads command and address, then sends them top bit first
`timescale 1ns/1ps
`include "spixpress_cfg.svh"

module spixpress_mosi_shift (
	input  logic                     i_clk,
	input  logic                     i_stall,
	input  logic                     i_cmd_sel,
	input  spixpress_pkg::spix_addr_t i_wb_addr,
	input  spixpress_pkg::spix_cfg_u  i_wb_data,
	output logic                     o_spi_mosi
);

	// Zero bits above the word address in the 24-bit byte address
	localparam int ADDR_PAD = 24 - `SPIX_AW - 2;

	logic [32:0] wdata_pipe;
	logic [7:0]  cmd_byte;

	// Read command for memory, otherwise the byte from the control word
	assign cmd_byte = i_cmd_sel ? `SPIX_READ_CMD : i_wb_data.fields.spi_byte;

	// Layout while idle
	// [32]     leading zero, goes out on the cycle the request is taken
	// [31:24]  command or user byte
	// [23:0]   byte address, word address followed by two zero bits
	always_ff @(posedge i_clk)
	begin
		if (!i_stall)
			wdata_pipe <= {1'b0, cmd_byte, {ADDR_PAD{1'b0}}, i_wb_addr, 2'b00};
		else
			// One bit per SCK cycle, zeros fill in behind
			wdata_pipe <= {wdata_pipe[31:0], 1'b0};
	end

	// Data bits of a read follow the address as zeros
	assign o_spi_mosi = wdata_pipe[32];

endmodule

// ==== hdl/spixpress_miso_capture.sv ====
// SPI MISO capture: delays SCK by one cycle and shifts flash data into the bus word
`timescale 1ns/1ps

module spixpress_miso_capture (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_wb_cyc,
	input  logic                    i_sck,
	input  logic                    i_user_mode,
	input  logic                    i_spi_miso,
	output spixpress_pkg::spix_cfg_u o_wb_data
);

	// SCK as the flash sees it, one cycle behind the register
	logic actual_sck;

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			actual_sck <= 1'b0;
		else
			actual_sck <= i_sck;
	end

	// Memory reads fill the whole raw word
	// User bytes land in the low byte and read back through the fields view
	always_ff @(posedge i_clk)
	begin
		if (actual_sck)
		begin
			if (i_user_mode)
				o_wb_data.raw <= {24'h0, o_wb_data.raw[6:0], i_spi_miso};
			else
				o_wb_data.raw <= {o_wb_data.raw[30:0], i_spi_miso};
		end
		else if (i_user_mode)
		begin
			// Stale read data above the byte is cleared
			o_wb_data.fields.unused <= '0;
			o_wb_data.fields.cs_n   <= 1'b0;
		end
	end

endmodule

// ==== hdl/spixpress_ctrl.sv ====
// SPI flash controller FSM: request decode, stall, ack, chip select, SCK and user mode
`timescale 1ns/1ps
`include "spixpress_cfg.svh"

module spixpress_ctrl (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_wb_cyc,
	input  logic                      i_wb_stb,
	input  logic                      i_cfg_stb,
	input  logic                      i_wb_we,
	input  spixpress_pkg::spix_addr_t  i_wb_addr,
	input  spixpress_pkg::spix_cfg_u   i_wb_data,
	input  spixpress_pkg::spix_count_t i_count,
	output spixpress_pkg::spix_load_e  o_load,
	output logic                      o_cmd_sel,
	output logic                      o_wb_stall,
	output logic                      o_wb_ack,
	output logic                      o_spi_cs_n,
	output logic                      o_spi_sck,
	output logic                      o_user_mode
);
	import spixpress_pkg::*;

	logic       bus_request;
	logic       next_request;
	logic       user_request;
	logic       cfg_write;
	logic       cfg_csn;
	spix_addr_t next_addr;

	//////////////////////////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////////////////////////

	// Requested chip select level of a control write
	assign cfg_csn = i_wb_data.raw[`SPIX_CSN_BIT];

	// Any accepted control write, either direction of chip select
	assign cfg_write = i_cfg_stb && !o_wb_stall && i_wb_we;

	// Memory read that starts or continues a flash transfer
	assign bus_request = i_wb_stb && !o_wb_stall && !i_wb_we && !o_user_mode;

	// Read of the word right after the one in flight
	// Only matters while the count is 2, stall is still high then
	assign next_request = i_wb_stb && !i_wb_we && !o_user_mode
		&& (i_wb_addr == next_addr);

	// Control write with chip select low sends one byte
	assign user_request = cfg_write && !cfg_csn;

	// Memory strobe picks the read command, else the user byte
	assign o_cmd_sel = i_wb_stb;

	// Timer load kind, chip select still low means the stream continues
	always_comb
	begin
		if (bus_request)
			o_load = o_spi_cs_n ? LOAD_FIRST : LOAD_NEXT;
		else if (user_request)
			o_load = LOAD_USER;
		else
			o_load = LOAD_NONE;
	end

	// Address expected for a pipelined read
	always_ff @(posedge i_clk)
	begin
		if (!o_wb_stall)
			next_addr <= i_wb_addr + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus side levels
	//////////////////////////////////////////////////////////////////////

	// Ack at the end of a transfer, or right away for anything that
	// does not touch the flash
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wb_ack <= 1'b0;
		else if (i_count == 7'd1)
			o_wb_ack <= i_wb_cyc;
		else if (i_wb_stb && !o_wb_stall && !bus_request)
			o_wb_ack <= 1'b1;
		else if (i_cfg_stb && !o_wb_stall && !user_request)
			o_wb_ack <= 1'b1;
		else
			o_wb_ack <= 1'b0;
	end

	// Stall through the transfer
	// Drops one cycle early when the next word can be streamed
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_wb_stall <= 1'b0;
		else if (bus_request || user_request)
			o_wb_stall <= 1'b1;
		else if (next_request && (i_count == 7'd2))
			o_wb_stall <= 1'b0;
		else
			o_wb_stall <= (i_count > 7'd1);
	end

	// User mode holds chip select low between control bytes
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_user_mode <= 1'b0;
		else if (cfg_write)
			o_user_mode <= !cfg_csn;
	end

	//////////////////////////////////////////////////////////////////////
	// SPI side levels
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_spi_cs_n <= 1'b1;
		else if (!i_wb_cyc && !o_user_mode)
			o_spi_cs_n <= 1'b1;
		else if (bus_request)
			o_spi_cs_n <= 1'b0;
		else if (cfg_write)
			o_spi_cs_n <= cfg_csn;
		else if (o_user_mode)
			o_spi_cs_n <= 1'b0;
		else if (i_count == 7'd1)
			// Read done and no follow-on word taken
			o_spi_cs_n <= 1'b1;
	end

	// SCK runs only while bits are left, abort stops it at once
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_spi_sck <= 1'b0;
		else if (bus_request || user_request)
			o_spi_sck <= 1'b1;
		else if (i_wb_cyc && (i_count > 7'd2))
			o_spi_sck <= 1'b1;
		else if (next_request && (i_count == 7'd2))
			o_spi_sck <= 1'b1;
		else
			o_spi_sck <= 1'b0;
	end

	// No clock to the flash while it is deselected
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_spi_cs_n |-> !o_spi_sck);

	// A user byte never loads a memory read count into the timer
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_user_mode |-> (i_count <= `SPIX_LOAD_USER));

endmodule

// ==== hdl/spixpress.sv ====
// SPI flash read controller top: bus slave port with slow reads, pipelined reads and user bytes
`timescale 1ns/1ps

module spixpress (
	input  logic                     i_clk,
	input  logic                     i_reset,
	// Bus slave port
	input  logic                     i_wb_cyc,
	input  logic                     i_wb_stb,
	input  logic                     i_cfg_stb,
	input  logic                     i_wb_we,
	input  spixpress_pkg::spix_addr_t i_wb_addr,
	input  spixpress_pkg::spix_cfg_u  i_wb_data,
	output logic                     o_wb_stall,
	output logic                     o_wb_ack,
	output spixpress_pkg::spix_cfg_u  o_wb_data,
	// SPI flash pins
	output logic                     o_spi_cs_n,
	output logic                     o_spi_sck,
	output logic                     o_spi_mosi,
	input  logic                     i_spi_miso
);
	import spixpress_pkg::*;

	spix_load_e  load_kind;
	spix_count_t bit_count;
	logic        cmd_sel;
	logic        user_mode;

	//////////////////////////////////////////////////////////////////////
	// Control and timing
	//////////////////////////////////////////////////////////////////////

	spixpress_ctrl u_ctrl (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_cfg_stb   (i_cfg_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_addr   (i_wb_addr),
		.i_wb_data   (i_wb_data),
		.i_count     (bit_count),
		.o_load      (load_kind),
		.o_cmd_sel   (cmd_sel),
		.o_wb_stall  (o_wb_stall),
		.o_wb_ack    (o_wb_ack),
		.o_spi_cs_n  (o_spi_cs_n),
		.o_spi_sck   (o_spi_sck),
		.o_user_mode (user_mode)
	);

	spixpress_bit_timer u_timer (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_wb_cyc (i_wb_cyc),
		.i_load   (load_kind),
		.o_count  (bit_count)
	);

	//////////////////////////////////////////////////////////////////////
	// Data paths
	//////////////////////////////////////////////////////////////////////

	// Shifter reloads whenever the bus is not stalled
	spixpress_mosi_shift u_mosi (
		.i_clk      (i_clk),
		.i_stall    (o_wb_stall),
		.i_cmd_sel  (cmd_sel),
		.i_wb_addr  (i_wb_addr),
		.i_wb_data  (i_wb_data),
		.o_spi_mosi (o_spi_mosi)
	);

	spixpress_miso_capture u_miso (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_sck       (o_spi_sck),
		.i_user_mode (user_mode),
		.i_spi_miso  (i_spi_miso),
		.o_wb_data   (o_wb_data)
	);

endmodule

// ==== verification/tb_flash_model.sv ====
// Behavioral SPI flash: answers slow reads with rule words and other commands with a status byte
`timescale 1ns/1ps

module tb_flash_model (
	input  logic        i_clk,
	input  logic        i_cs_n,
	input  logic        i_sck,
	input  logic        i_mosi,
	input  logic [7:0]  i_status,
	output logic        o_miso,
	output logic [7:0]  o_cmd,
	output logic [23:0] o_addr
);

	// SCK as the flash pins see it, one clock behind the controller register
	logic        flash_sck = 1'b0;
	int          rx_bits = 0;
	int          tx_bits = 0;
	int          offset;
	logic [31:0] word;

	// Data word stored at a word address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return addr * 32'd1664525 + 32'd1013904223;
	endfunction

	initial
		o_miso = 1'b0;

	// Rising side, command byte then 24 address bits
	always @(posedge i_clk)
	begin
		if (i_cs_n)
		begin
			flash_sck <= 1'b0;
			rx_bits   <= 0;
		end
		else
		begin
			flash_sck <= i_sck;
			if (flash_sck)
			begin
				if (rx_bits < 8)
					o_cmd <= {o_cmd[6:0], i_mosi};
				else if (rx_bits < 32)
					o_addr <= {o_addr[22:0], i_mosi};
				rx_bits <= rx_bits + 1;
			end
		end
	end

	// Falling side, next outgoing bit
	always @(negedge i_clk)
	begin
		if (i_cs_n)
		begin
			tx_bits = 0;
			o_miso  = 1'b0;
		end
		else if (flash_sck)
		begin
			if ((o_cmd == 8'h03) && (tx_bits >= 32))
			begin
				// Word stream from the received address onward
				offset = tx_bits - 32;
				word   = word_at({10'h0, o_addr[23:2]} + offset / 32);
				o_miso = word[31 - (offset % 32)];
			end
			else if ((o_cmd != 8'h03) && (tx_bits >= 8))
				o_miso = i_status[7 - (tx_bits % 8)];
			else
				o_miso = 1'b0;
			tx_bits++;
		end
	end

endmodule

// ==== verification/tb_spixpress.sv ====
// Testbench that runs directed bus transfers on the SPI flash read controller with a flash model
`timescale 1ns/1ps
`include "spixpress_cfg.svh"

module tb_spixpress;
	import spixpress_pkg::*;

	// Tests take about 420 clocks of 8 ns, so 20 us is a wide margin
	localparam int WATCHDOG_NS = 20000;

	// Edges from the accepting edge to the edge that raises ack
	localparam int READ_EDGES = 65;
	localparam int NEXT_EDGES = 32;
	localparam int USER_EDGES = 9;
	// Immediate requests raise ack on the accepting edge itself
	localparam int NOW_EDGES  = 0;

	logic        i_clk = 1'b0;
	logic        i_reset;
	logic        i_wb_cyc;
	logic        i_wb_stb;
	logic        i_cfg_stb;
	logic        i_wb_we;
	spix_addr_t  i_wb_addr;
	spix_cfg_u   i_wb_data;
	logic        o_wb_stall;
	logic        o_wb_ack;
	spix_cfg_u   o_wb_data;
	logic        o_spi_cs_n;
	logic        o_spi_sck;
	logic        o_spi_mosi;
	logic        i_spi_miso;
	logic [7:0]  status_byte;
	logic [7:0]  flash_cmd;
	logic [23:0] flash_addr;
	logic [31:0] rng_state = 32'h5c51_82ba;
	int          error_count = 0;

	always #4 i_clk = !i_clk;

	spixpress dut_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wb_cyc   (i_wb_cyc),
		.i_wb_stb   (i_wb_stb),
		.i_cfg_stb  (i_cfg_stb),
		.i_wb_we    (i_wb_we),
		.i_wb_addr  (i_wb_addr),
		.i_wb_data  (i_wb_data),
		.o_wb_stall (o_wb_stall),
		.o_wb_ack   (o_wb_ack),
		.o_wb_data  (o_wb_data),
		.o_spi_cs_n (o_spi_cs_n),
		.o_spi_sck  (o_spi_sck),
		.o_spi_mosi (o_spi_mosi),
		.i_spi_miso (i_spi_miso)
	);

	tb_flash_model flash_i (
		.i_clk    (i_clk),
		.i_cs_n   (o_spi_cs_n),
		.i_sck    (o_spi_sck),
		.i_mosi   (o_spi_mosi),
		.i_status (status_byte),
		.o_miso   (i_spi_miso),
		.o_cmd    (flash_cmd),
		.o_addr   (flash_addr)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference words and random numbers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_step(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = lcg_step(rng_state);
		return rng_state;
	endfunction

	// Flash word at address A is the LCG step of A
	function automatic logic [31:0] rule_word(input spix_addr_t addr);
		return lcg_step(32'(addr));
	endfunction

	// Top address bit kept clear so a short run of words never wraps
	function automatic spix_addr_t random_addr();
		logic [31:0] r;
		r = next_random();
		return spix_addr_t'(r[`SPIX_AW-2:0]);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic fail(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			fail($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
				$time, name, expected, actual));
	endtask

	task automatic check_byte(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected)
			fail($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
				$time, name, expected, actual));
	endtask

	task automatic check_word(input string name, input spix_cfg_u actual,
		input spix_cfg_u expected);
		if (actual.raw !== expected.raw)
			fail($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
				$time, name, expected.raw, actual.raw));
	endtask

	task automatic check_addr(input string name, input spix_addr_t actual,
		input spix_addr_t expected);
		if (actual !== expected)
			fail($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
				$time, name, expected, actual));
	endtask

	task automatic check_cycles(input string name, input int actual, input int expected);
		if (actual != expected)
			fail($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
				$time, name, expected, actual));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus driving
	//////////////////////////////////////////////////////////////////////

	// Present a request and hold it until stall is low so the next edge takes it
	task automatic issue_request(input logic mem, input logic we, input spix_addr_t addr,
		input spix_cfg_u data);
		int waited;
		@(negedge i_clk);
		i_wb_cyc  = 1'b1;
		i_wb_stb  = mem;
		i_cfg_stb = !mem;
		i_wb_we   = we;
		i_wb_addr = addr;
		i_wb_data = data;
		waited = 0;
		while (o_wb_stall)
		begin
			@(negedge i_clk);
			waited++;
			if (waited > 100)
				fail("Stall never dropped for a new request");
		end
	endtask

	// Count edges until ack and optionally watch that the SPI pins stay idle
	task automatic wait_ack(input string what, input int expected, input bit pins,
		input logic cs_level);
		int edges;
		edges = -1;
		do
		begin
			@(negedge i_clk);
			edges++;
			i_wb_stb  = 1'b0;
			i_cfg_stb = 1'b0;
			if (pins)
			begin
				check_bit("o_spi_cs_n", o_spi_cs_n, cs_level);
				check_bit("o_spi_sck", o_spi_sck, 1'b0);
			end
			if (edges > 100)
				fail({what, ": ack never came"});
		end
		while (!o_wb_ack);
		check_cycles({what, " ack latency"}, edges, expected);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_levels();
		@(negedge i_clk);
		check_bit("o_spi_cs_n", o_spi_cs_n, 1'b1);
		check_bit("o_spi_sck", o_spi_sck, 1'b0);
		check_bit("o_wb_stall", o_wb_stall, 1'b0);
		check_bit("o_wb_ack", o_wb_ack, 1'b0);
	endtask

	task automatic single_read(input spix_addr_t addr);
		spix_cfg_u expect_word;
		expect_word.raw = rule_word(addr);
		issue_request(1'b1, 1'b0, addr, '0);
		wait_ack("single read", READ_EDGES, 1'b0, 1'b0);
		check_word("o_wb_data", o_wb_data, expect_word);
		check_bit("o_spi_cs_n", o_spi_cs_n, 1'b1);
		check_byte("flash command", flash_cmd, `SPIX_READ_CMD);
		check_addr("flash address", flash_addr[`SPIX_AW+1:2], addr);
	endtask

	task automatic pipelined_reads(input spix_addr_t base);
		spix_cfg_u expect_word;
		int        edges;
		int        acks;
		int        presented;
		logic      taking;
		issue_request(1'b1, 1'b0, base, '0);
		taking = 1'b1;
		edges = -1;
		acks = 0;
		presented = 1;
		while (acks < 4)
		begin
			@(negedge i_clk);
			edges++;
			// Next address goes up as soon as the previous one is taken
			if (taking)
			begin
				if (presented < 4)
				begin
					i_wb_addr = base + presented;
					presented++;
				end
				else
					i_wb_stb = 1'b0;
			end
			taking = i_wb_stb && !o_wb_stall;
			// Chip select stays low until the ack of the last word
			check_bit("o_spi_cs_n", o_spi_cs_n, (acks == 3) && (edges == NEXT_EDGES));
			if (o_wb_ack)
			begin
				expect_word.raw = rule_word(base + acks);
				check_word("o_wb_data", o_wb_data, expect_word);
				check_cycles("pipelined read ack latency", edges,
					(acks == 0) ? READ_EDGES : NEXT_EDGES);
				acks++;
				edges = 0;
			end
			if (edges > 100)
				fail("Pipelined read ack never came");
		end
	endtask

	task automatic memory_write();
		spix_cfg_u data;
		data.raw = next_random();
		issue_request(1'b1, 1'b1, random_addr(), data);
		wait_ack("memory write", NOW_EDGES, 1'b1, 1'b1);
		repeat (3)
		begin
			@(negedge i_clk);
			check_bit("o_spi_cs_n", o_spi_cs_n, 1'b1);
			check_bit("o_spi_sck", o_spi_sck, 1'b0);
		end
	endtask

	task automatic user_bytes();
		spix_cfg_u ctrl_word;
		spix_cfg_u expect_word;
		// Command byte with chip select held low
		ctrl_word.raw = '0;
		ctrl_word.fields.spi_byte = 8'h05;
		issue_request(1'b0, 1'b1, '0, ctrl_word);
		wait_ack("user command byte", USER_EDGES, 1'b0, 1'b0);
		check_bit("o_spi_cs_n", o_spi_cs_n, 1'b0);
		check_byte("flash command", flash_cmd, 8'h05);
		// Second byte returns the status
		ctrl_word.fields.spi_byte = 8'h00;
		issue_request(1'b0, 1'b1, '0, ctrl_word);
		wait_ack("user status byte", USER_EDGES, 1'b0, 1'b0);
		expect_word.raw = '0;
		expect_word.fields.spi_byte = status_byte;
		check_word("o_wb_data", o_wb_data, expect_word);
		// Memory read is answered at once while the bus owns chip select
		issue_request(1'b1, 1'b0, random_addr(), '0);
		wait_ack("read in user mode", NOW_EDGES, 1'b1, 1'b0);
		// Release chip select
		ctrl_word.fields.cs_n = 1'b1;
		issue_request(1'b0, 1'b1, '0, ctrl_word);
		wait_ack("chip select release", NOW_EDGES, 1'b0, 1'b0);
		check_bit("o_spi_cs_n", o_spi_cs_n, 1'b1);
	endtask

	task automatic bus_abort();
		issue_request(1'b1, 1'b0, random_addr(), '0);
		@(negedge i_clk);
		i_wb_stb = 1'b0;
		repeat (19) @(negedge i_clk);
		check_bit("o_spi_cs_n", o_spi_cs_n, 1'b0);
		i_wb_cyc = 1'b0;
		@(negedge i_clk);
		check_bit("o_spi_cs_n", o_spi_cs_n, 1'b1);
		check_bit("o_wb_stall", o_wb_stall, 1'b0);
		check_bit("o_spi_sck", o_spi_sck, 1'b0);
		check_bit("o_wb_ack", o_wb_ack, 1'b0);
		// Fresh read after the abort
		single_read(random_addr());
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		i_reset   = 1'b1;
		i_wb_cyc  = 1'b0;
		i_wb_stb  = 1'b0;
		i_cfg_stb = 1'b0;
		i_wb_we   = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		r = next_random();
		status_byte = r[7:0];
		repeat (10) @(negedge i_clk);
		i_reset = 1'b0;
		reset_levels();
		single_read(random_addr());
		pipelined_reads(random_addr());
		memory_write();
		user_bytes();
		bus_abort();
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$fatal(1, "Timeout");
	end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/spixpress_pkg.sv
hdl/spixpress_bit_timer.sv
hdl/spixpress_mosi_shift.sv
hdl/spixpress_miso_capture.sv
hdl/spixpress_ctrl.sv
hdl/spixpress.sv
verification/tb_flash_model.sv
verification/tb_spixpress.sv

// ==== Bender.yml ====
package:
  name: spixpress

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/spixpress_pkg.sv
      - hdl/spixpress_bit_timer.sv
      - hdl/spixpress_mosi_shift.sv
      - hdl/spixpress_miso_capture.sv
      - hdl/spixpress_ctrl.sv
      - hdl/spixpress.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/tb_flash_model.sv
      - verification/tb_spixpress.sv
